/* files.f */
sat_bin_pkg.sv
var_chain.sv
level_tree.sv
clause_slot_select.sv
analyze_fsm.sv
xfer_counter.sv
var_bin.sv
var_bin_tb.sv

/* Bender.yml */
package:
  name: var_bin

sources:
  - sat_bin_pkg.sv
  - var_chain.sv
  - level_tree.sv
  - clause_slot_select.sv
  - analyze_fsm.sv
  - xfer_counter.sv
  - var_bin.sv
  - target: test
    files:
      - var_bin_tb.sv

/* var_bin_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module var_bin_tb
	import sat_bin_pkg::*;
();

	localparam int NUM_ROUNDS = 20;
	localparam int ANALYSES_PER_ROUND = 10;
	localparam int NUM_XFERS = 4 + 2 * NUM_ROUNDS;
	localparam int XFER_CYCLES = NUM_VARS + 4;
	localparam int ANALYZE_CYCLES = 8;
	localparam int ANALYZE_WAIT_MAX = 8;
	localparam int MAX_CYCLES = 2 * (NUM_XFERS * XFER_CYCLES
		+ NUM_ROUNDS * ANALYSES_PER_ROUND * ANALYZE_CYCLES + 10);

	logic clk;
	logic rst;
	logic set_states_i;
	logic get_states_i;
	var_state_t state_i;
	var_state_t state_o;
	logic xfer_done_o;
	logic analyze_i;
	analyze_req_t analyze_req_i;
	clause_lens_t clause_lens_i;
	logic done_analyze_o;
	level_t bkt_level_o;
	slot_mask_t wr_learntc_o;

	var_state_t model [NUM_VARS];
	var_state_t stim [NUM_VARS];
	int cycle_cnt = 0;

	var_bin dut (
		.clk            (clk),
		.rst            (rst),
		.set_states_i   (set_states_i),
		.get_states_i   (get_states_i),
		.state_i        (state_i),
		.state_o        (state_o),
		.xfer_done_o    (xfer_done_o),
		.analyze_i      (analyze_i),
		.analyze_req_i  (analyze_req_i),
		.clause_lens_i  (clause_lens_i),
		.done_analyze_o (done_analyze_o),
		.bkt_level_o    (bkt_level_o),
		.wr_learntc_o   (wr_learntc_o)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			abort_run("the run went past its cycle budget without finishing");
	end

	task automatic fill_stim();
		for (int i = 0; i < NUM_VARS; i++)
		begin
			stim[i].value = var_value_t'($urandom_range(0, 7));
			stim[i].level = level_t'($urandom_range(0, 15));
		end
	endtask

	// set shifts stim in, get compares each head word with the model
	task automatic transfer(input logic do_get);
		@(posedge clk);
		if (do_get)
			get_states_i <= 1'b1;
		else
		begin
			set_states_i <= 1'b1;
			state_i <= stim[0];
		end
		for (int k = 0; k < NUM_VARS; k++)
		begin
			@(negedge clk);
			check_value("xfer_done_o", xfer_done_o, 1'b0);
			if (do_get)
				check_value("state_o", state_o, model[k]);
			@(posedge clk);
			if (!do_get && k < NUM_VARS - 1)
				state_i <= stim[k+1];
		end
		@(negedge clk);
		check_value("xfer_done_o", xfer_done_o, 1'b1);
		@(posedge clk);
		set_states_i <= 1'b0;
		get_states_i <= 1'b0;
		@(negedge clk);
		check_value("xfer_done_o", xfer_done_o, 1'b0);
		if (!do_get)
			model = stim;
	endtask

	task automatic run_analysis();
		analyze_req_t req;
		clause_lens_t lens;
		slot_mask_t exp_wr;
		level_t exp_bkt;
		logic exp_hit;
		int best;
		int strobes;
		int cycles;
		req.conflict_mask = var_mask_t'($urandom());
		req.cur_level = level_t'($urandom_range(0, 15));
		// small lengths so that ties between slots are common
		for (int i = 0; i < NUM_SLOTS; i++)
			lens[i] = clause_len_t'($urandom_range(0, 3));
		best = 0;
		for (int i = 1; i < NUM_SLOTS; i++)
			if (lens[i] > lens[best])
				best = i;
		exp_wr = '0;
		exp_wr[best] = 1'b1;
		exp_bkt = '0;
		exp_hit = 1'b0;
		for (int i = 0; i < NUM_VARS; i++)
		begin
			if (req.conflict_mask[i] && model[i].level < req.cur_level && model[i].level > exp_bkt)
				exp_bkt = model[i].level;
			if (req.conflict_mask[i] && model[i].level == req.cur_level)
				exp_hit = 1'b1;
		end
		@(posedge clk);
		analyze_i <= 1'b1;
		analyze_req_i <= req;
		clause_lens_i <= lens;
		strobes = 0;
		cycles = 0;
		@(negedge clk);
		while (!done_analyze_o)
		begin
			if (wr_learntc_o != '0)
			begin
				strobes++;
				check_value("wr_learntc_o", wr_learntc_o, exp_wr);
			end
			cycles++;
			if (cycles > ANALYZE_WAIT_MAX)
				abort_run("done_analyze_o never came after an analysis request");
			@(negedge clk);
		end
		check_value("wr_learntc_o strobe count", strobes, 1);
		check_value("analysis latency", cycles, exp_hit ? 5 : 4);
		check_value("bkt_level_o", bkt_level_o, exp_bkt);
		@(posedge clk);
		analyze_i <= 1'b0;
		@(negedge clk);
		check_value("done_analyze_o", done_analyze_o, 1'b0);
		check_value("wr_learntc_o", wr_learntc_o, '0);
		check_value("bkt_level_o", bkt_level_o, exp_bkt);
		if (exp_hit)
		begin
			for (int i = 0; i < NUM_VARS; i++)
			begin
				if (model[i].level > exp_bkt)
				begin
					model[i].value = VALUE_UNASSIGNED;
					model[i].level = '0;
				end
			end
		end
	endtask

	initial
	begin
		int seed_ret;
		clk = 1'b0;
		rst = 1'b1;
		set_states_i = 1'b0;
		get_states_i = 1'b0;
		state_i = '0;
		analyze_i = 1'b0;
		analyze_req_i = '0;
		clause_lens_i = '0;
		for (int i = 0; i < NUM_VARS; i++)
			model[i] = '0;
		seed_ret = $urandom(32'h1763);
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("xfer_done_o", xfer_done_o, 1'b0);
		check_value("done_analyze_o", done_analyze_o, 1'b0);
		check_value("wr_learntc_o", wr_learntc_o, '0);
		check_value("bkt_level_o", bkt_level_o, '0);
		transfer(1'b1);
		// second get shows that a get leaves the chain intact
		fill_stim();
		transfer(1'b0);
		transfer(1'b1);
		transfer(1'b1);
		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			fill_stim();
			transfer(1'b0);
			for (int a = 0; a < ANALYSES_PER_ROUND; a++)
				run_analysis();
			transfer(1'b1);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* var_bin.sv */
`timescale 1ns/1ns
`default_nettype none

module var_bin
	import sat_bin_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,

	input  wire logic          set_states_i,
	input  wire logic          get_states_i,
	input  wire var_state_t    state_i,
	output var_state_t         state_o,
	output logic               xfer_done_o,

	input  wire logic          analyze_i,
	input  wire analyze_req_t  analyze_req_i,
	input  wire clause_lens_t  clause_lens_i,
	output logic               done_analyze_o,
	output level_t             bkt_level_o,
	output slot_mask_t         wr_learntc_o
);

	var_states_t states;
	logic shift;
	logic rotate;
	logic capture;
	logic learn;
	logic backtrack;
	logic cur_hit;

	xfer_counter u_xfer_counter (
		.clk      (clk),
		.rst      (rst),
		.set_i    (set_states_i),
		.get_i    (get_states_i),
		.shift_o  (shift),
		.rotate_o (rotate),
		.done_o   (xfer_done_o)
	);

	var_chain u_var_chain (
		.clk         (clk),
		.rst         (rst),
		.shift_i     (shift),
		.rotate_i    (rotate),
		.state_i     (state_i),
		.backtrack_i (backtrack),
		.bkt_level_i (bkt_level_o),
		.states_o    (states)
	);

	// head of the chain is the serial output
	assign state_o = states[0];

	level_tree u_level_tree (
		.clk         (clk),
		.rst         (rst),
		.capture_i   (capture),
		.states_i    (states),
		.req_i       (analyze_req_i),
		.bkt_level_o (bkt_level_o),
		.cur_hit_o   (cur_hit)
	);

	clause_slot_select u_clause_slot_select (
		.clk           (clk),
		.rst           (rst),
		.learn_i       (learn),
		.clause_lens_i (clause_lens_i),
		.wr_learntc_o  (wr_learntc_o)
	);

	analyze_fsm u_analyze_fsm (
		.clk         (clk),
		.rst         (rst),
		.analyze_i   (analyze_i),
		.cur_hit_i   (cur_hit),
		.capture_o   (capture),
		.learn_o     (learn),
		.backtrack_o (backtrack),
		.done_o      (done_analyze_o)
	);

endmodule

`default_nettype wire

/* xfer_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module xfer_counter
	import sat_bin_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  set_i,
	input  wire logic  get_i,
	output logic       shift_o,
	output logic       rotate_o,
	output logic       done_o
);

	xfer_cnt_t cnt;
	logic finished;
	logic last_shift;

	assign shift_o = (set_i || get_i) && !finished;
	assign rotate_o = get_i;
	assign last_shift = shift_o && (cnt == xfer_cnt_t'(NUM_VARS - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt <= '0;
			finished <= 1'b0;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= last_shift;
			// finished holds until the host drops its request
			if (!(set_i || get_i))
			begin
				cnt <= '0;
				finished <= 1'b0;
			end
			else if (last_shift)
			begin
				cnt <= '0;
				finished <= 1'b1;
			end
			else if (shift_o)
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	a_one_request: assert property (
		@(posedge clk) disable iff (rst)
		!(set_i && get_i)
	);

endmodule

`default_nettype wire

/* analyze_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module analyze_fsm
	import sat_bin_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  analyze_i,
	input  wire logic  cur_hit_i,
	output logic       capture_o,
	output logic       learn_o,
	output logic       backtrack_o,
	output logic       done_o
);

	analyze_state_t state;
	analyze_state_t state_nxt;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ANALYZE_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ANALYZE_IDLE:
			begin
				// request is still high while done is out
				if (analyze_i && !done_o)
					state_nxt = COLLECT_LEVELS;
			end
			COLLECT_LEVELS:
			begin
				state_nxt = ADD_LEARNT_CLAUSE;
			end
			ADD_LEARNT_CLAUSE:
			begin
				if (cur_hit_i)
					state_nxt = BACKTRACK;
				else
					state_nxt = ANALYZE_DONE;
			end
			BACKTRACK:
			begin
				state_nxt = ANALYZE_DONE;
			end
			ANALYZE_DONE:
			begin
				state_nxt = ANALYZE_IDLE;
			end
			default:
			begin
				state_nxt = ANALYZE_IDLE;
			end
		endcase
	end

	assign capture_o = (state == COLLECT_LEVELS);
	assign learn_o = (state == ADD_LEARNT_CLAUSE);
	assign backtrack_o = (state == BACKTRACK);

	always_ff @(posedge clk)
	begin
		if (rst)
			done_o <= 1'b0;
		else
			done_o <= (state == ANALYZE_DONE);
	end

	// host keeps its request up until the done pulse
	a_request_held: assert property (
		@(posedge clk) disable iff (rst)
		(state != ANALYZE_IDLE) |-> analyze_i
	);

endmodule

`default_nettype wire

/* clause_slot_select.sv */
`timescale 1ns/1ns
`default_nettype none

module clause_slot_select
	import sat_bin_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          learn_i,
	input  wire clause_lens_t  clause_lens_i,
	output slot_mask_t         wr_learntc_o
);

	clause_len_t best_len;
	slot_mask_t best_sel;

	// strict compare keeps the lowest index on equal lengths
	always_comb
	begin
		best_len = clause_lens_i[0];
		best_sel = '0;
		best_sel[0] = 1'b1;
		for (int i = 1; i < NUM_SLOTS; i++)
		begin
			if (clause_lens_i[i] > best_len)
			begin
				best_len = clause_lens_i[i];
				best_sel = '0;
				best_sel[i] = 1'b1;
			end
		end
	end

	// one write strobe per learnt clause
	always_ff @(posedge clk)
	begin
		if (rst)
			wr_learntc_o <= '0;
		else if (learn_i)
			wr_learntc_o <= best_sel;
		else
			wr_learntc_o <= '0;
	end

	a_strobe_single: assert property (
		@(posedge clk) disable iff (rst)
		(wr_learntc_o != '0) |=> (wr_learntc_o == '0)
	);

endmodule

`default_nettype wire

/* level_tree.sv */
`timescale 1ns/1ns
`default_nettype none

module level_tree
	import sat_bin_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          capture_i,
	input  wire var_states_t   states_i,
	input  wire analyze_req_t  req_i,
	output level_t             bkt_level_o,
	output logic               cur_hit_o
);

	level_t node [NUM_VARS];
	var_mask_t at_cur;

	always_comb
	begin
		// only conflict vars below the current level count as leaves
		for (int i = 0; i < NUM_VARS; i++)
		begin
			if (req_i.conflict_mask[i] && (states_i[i].level < req_i.cur_level))
				node[i] = states_i[i].level;
			else
				node[i] = '0;
			at_cur[i] = req_i.conflict_mask[i] && (states_i[i].level == req_i.cur_level);
		end
		// pairwise reduction where an odd leftover passes straight up
		for (int w = NUM_VARS; w > 1; w = (w + 1) / 2)
		begin
			for (int j = 0; j < (w + 1) / 2; j++)
			begin
				if ((2 * j + 1) < w)
					node[j] = (node[2*j] > node[2*j+1]) ? node[2*j] : node[2*j+1];
				else
					node[j] = node[2*j];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bkt_level_o <= '0;
			cur_hit_o <= 1'b0;
		end
		else if (capture_i)
		begin
			bkt_level_o <= node[0];
			cur_hit_o <= |at_cur;
		end
	end

endmodule

`default_nettype wire

/* var_chain.sv */
`timescale 1ns/1ns
`default_nettype none

module var_chain
	import sat_bin_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        shift_i,
	input  wire logic        rotate_i,
	input  wire var_state_t  state_i,
	input  wire logic        backtrack_i,
	input  wire level_t      bkt_level_i,
	output var_states_t      states_o
);

	var_states_t cells;
	var_state_t tail_in;

	// a get feeds the head word back in, so the chain keeps its contents
	assign tail_in = rotate_i ? cells[0] : state_i;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cells <= '0;
		end
		else if (shift_i)
		begin
			for (int i = 0; i < NUM_VARS - 1; i++)
			begin
				cells[i] <= cells[i+1];
			end
			cells[NUM_VARS-1] <= tail_in;
		end
		else if (backtrack_i)
		begin
			for (int i = 0; i < NUM_VARS; i++)
			begin
				// unassign everything decided above the backtrack level
				if (cells[i].level > bkt_level_i)
				begin
					cells[i].value <= VALUE_UNASSIGNED;
					cells[i].level <= '0;
				end
			end
		end
	end

	assign states_o = cells;

	// transfer and analysis must never overlap
	a_no_shift_in_backtrack: assert property (
		@(posedge clk) disable iff (rst)
		!(shift_i && backtrack_i)
	);

endmodule

`default_nettype wire

/* sat_bin_pkg.sv */
`default_nettype none

package sat_bin_pkg;

	// bin geometry
	localparam int NUM_VARS = 24;
	localparam int NUM_SLOTS = 12;

	// field widths
	localparam int VALUE_W = 3;
	localparam int LEVEL_W = 8;
	localparam int LEN_W = 8;

	typedef logic [VALUE_W-1:0] var_value_t;
	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [LEN_W-1:0] clause_len_t;
	typedef logic [NUM_VARS-1:0] var_mask_t;
	typedef logic [NUM_SLOTS-1:0] slot_mask_t;
	typedef logic [4:0] xfer_cnt_t;

	// code of a free variable
	localparam var_value_t VALUE_UNASSIGNED = '0;

	// one word on the state chain
	typedef struct packed {
		var_value_t value;
		level_t level;
	} var_state_t;

	typedef struct packed {
		var_mask_t conflict_mask;
		level_t cur_level;
	} analyze_req_t;

	typedef clause_len_t [NUM_SLOTS-1:0] clause_lens_t;
	typedef var_state_t [NUM_VARS-1:0] var_states_t;

	typedef enum logic [2:0] {
		ANALYZE_IDLE,
		COLLECT_LEVELS,
		ADD_LEARNT_CLAUSE,
		BACKTRACK,
		ANALYZE_DONE
	} analyze_state_t;

endpackage

`default_nettype wire
